// ==== src/frontend_pkg.sv ====
////////////////////////////////////////
// shared widths, queue sizing, opcode and
// class codes, and the instruction format
// union for the two-wide front end
////////////////////////////////////////

package frontend_pkg;

  localparam int xlen             = 64; // pc and immediate width
  localparam int ilen             = 32; // one instruction
  localparam int num_slots        = 2;  // instructions per fetch
  localparam int fetch_bytes      = 8;  // bytes per fetch pair
  localparam int queue_depth      = 8;
  localparam int queue_ptr_bits   = 3;
  localparam int queue_count_bits = 4;  // holds 0 .. queue_depth

  ////////////////////////////////////////
  // operation classes
  ////////////////////////////////////////
  localparam logic [2:0] class_alu    = 3'd0; // reg and imm arithmetic
  localparam logic [2:0] class_load   = 3'd1;
  localparam logic [2:0] class_store  = 3'd2;
  localparam logic [2:0] class_branch = 3'd3; // conditional only
  localparam logic [2:0] class_jal    = 3'd4;
  localparam logic [2:0] class_jalr   = 3'd5;
  localparam logic [2:0] class_upper  = 3'd6; // lui, auipc
  localparam logic [2:0] class_other  = 3'd7;

  // base opcodes, bits 6:0 of the word
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;

  ////////////////////////////////////////
  // format views of one fetched word
  ////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_format_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_format_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_format_t;

  typedef struct packed {
    logic       imm12;   // sign bit
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_format_t;

  typedef struct packed {
    logic [19:0] imm;    // lands in bits 31:12
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_format_t;

  typedef struct packed {
    logic       imm20;   // sign bit
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_format_t;

  // the opcode picks which view is meaningful
  typedef union packed {
    logic [ilen-1:0] raw;
    r_format_t       r_format;
    i_format_t       i_format;
    s_format_t       s_format;
    b_format_t       b_format;
    u_format_t       u_format;
    j_format_t       j_format;
  } inst_word_u;

endpackage

// ==== src/fetch_stage.sv ====
////////////////////////////////////////
// fetch stage: pc register, aligned memory
// address and next pc, and the split of the
// 64-bit memory word into two slots
////////////////////////////////////////

`timescale 1ns/1ps

module fetch_stage (
  input  logic                                                      clock,
  input  logic                                                      reset,
  input  logic                                                      take_branch,
  input  logic [frontend_pkg::xlen-1:0]                             branch_target,
  input  logic [63:0]                                               imem_data,
  input  logic                                                      imem_valid,
  input  logic                                                      queue_room,
  output logic [frontend_pkg::xlen-1:0]                             imem_addr,
  output logic [frontend_pkg::num_slots-1:0]                        fetch_valid,
  output logic [frontend_pkg::num_slots-1:0][frontend_pkg::ilen-1:0] fetch_inst,
  output logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] fetch_pc
);

  logic [frontend_pkg::xlen-1:0] pc;        // pair being fetched
  logic [frontend_pkg::xlen-1:0] pc_plus_8;
  logic [frontend_pkg::xlen-1:0] next_pc;
  logic                          accept;    // pair taken this cycle
  logic                          pc_enable;

  assign imem_addr = {pc[frontend_pkg::xlen-1:3], 3'b000}; // memory is 8-byte wide

  // low half of the memory word is the lower address
  assign fetch_inst[0] = imem_data[31:0];
  assign fetch_inst[1] = imem_data[63:32];

  assign fetch_valid = {frontend_pkg::num_slots{imem_valid}};

  assign fetch_pc[0] = pc;
  assign fetch_pc[1] = pc + 64'd4;

  assign pc_plus_8 = pc + frontend_pkg::fetch_bytes;
  assign accept    = imem_valid && queue_room;

  // a redirect overrides any stall
  assign next_pc   = take_branch ? branch_target : pc_plus_8;
  assign pc_enable = accept || take_branch;

  ////////////////////////////////////////
  // pc register
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      pc <= '0;                 // boot at address 0
    else if (pc_enable)
      pc <= next_pc;
  end

  // targets must land on a pair boundary
  a_target_aligned: assert property (
    @(posedge clock) disable iff (reset)
    take_branch |-> (branch_target[2:0] == 3'b000)
  );

endmodule

// ==== src/predecode.sv ====
////////////////////////////////////////
// predecode: registers each accepted pair
// with class, register numbers and the
// sign-extended immediate of its format
////////////////////////////////////////

`timescale 1ns/1ps

module predecode (
  input  logic                                                      clock,
  input  logic                                                      reset,
  input  logic                                                      flush,
  input  logic [frontend_pkg::num_slots-1:0]                        fetch_valid,
  input  logic [frontend_pkg::num_slots-1:0][frontend_pkg::ilen-1:0] fetch_inst,
  input  logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] fetch_pc,
  input  logic                                                      imem_valid,
  input  logic                                                      queue_room,
  output logic [frontend_pkg::num_slots-1:0]                        dec_valid,
  output logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] dec_pc,
  output logic [frontend_pkg::num_slots-1:0][frontend_pkg::ilen-1:0] dec_inst,
  output logic [frontend_pkg::num_slots-1:0][2:0]                   dec_class,
  output logic [frontend_pkg::num_slots-1:0][4:0]                   dec_rd,
  output logic [frontend_pkg::num_slots-1:0][4:0]                   dec_rs1,
  output logic [frontend_pkg::num_slots-1:0][4:0]                   dec_rs2,
  output logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] dec_imm
);

  frontend_pkg::inst_word_u [frontend_pkg::num_slots-1:0] word; // format views

  logic [frontend_pkg::num_slots-1:0][2:0]                    cls;
  logic [frontend_pkg::num_slots-1:0][4:0]                    rd;
  logic [frontend_pkg::num_slots-1:0][4:0]                    rs1;
  logic [frontend_pkg::num_slots-1:0][4:0]                    rs2;
  logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] imm;
  logic                                                       accept;

  assign word   = fetch_inst;
  assign accept = imem_valid && queue_room; // same rule as the pc advance

  ////////////////////////////////////////
  // per-slot class, registers, immediate
  ////////////////////////////////////////
  always_comb
  begin
    for (int s = 0; s < frontend_pkg::num_slots; s++)
    begin
      // register fields sit at fixed positions in every format
      rd[s]  = word[s].r_format.rd;
      rs1[s] = word[s].r_format.rs1;
      rs2[s] = 5'd0;
      imm[s] = '0;                                    // reg-reg has none
      case (word[s].r_format.opcode)
        frontend_pkg::opcode_op:
        begin
          cls[s] = frontend_pkg::class_alu;
          rs2[s] = word[s].r_format.rs2;
        end
        frontend_pkg::opcode_op_imm, frontend_pkg::opcode_load, frontend_pkg::opcode_jalr:
        begin
          if (word[s].r_format.opcode == frontend_pkg::opcode_load)
            cls[s] = frontend_pkg::class_load;
          else if (word[s].r_format.opcode == frontend_pkg::opcode_jalr)
            cls[s] = frontend_pkg::class_jalr;
          else
            cls[s] = frontend_pkg::class_alu;
          imm[s] = {{52{word[s].i_format.imm[11]}}, word[s].i_format.imm};
        end
        frontend_pkg::opcode_store:
        begin
          cls[s] = frontend_pkg::class_store;
          rd[s]  = 5'd0;                             // bits 11:7 are imm_lo here
          rs2[s] = word[s].s_format.rs2;
          imm[s] = {{52{word[s].s_format.imm_hi[6]}}, word[s].s_format.imm_hi,
                    word[s].s_format.imm_lo};
        end
        frontend_pkg::opcode_branch:
        begin
          cls[s] = frontend_pkg::class_branch;
          rd[s]  = 5'd0;
          rs2[s] = word[s].b_format.rs2;
          imm[s] = {{51{word[s].b_format.imm12}}, word[s].b_format.imm12,
                    word[s].b_format.imm11, word[s].b_format.imm10_5,
                    word[s].b_format.imm4_1, 1'b0};     // halfword offset
        end
        frontend_pkg::opcode_lui, frontend_pkg::opcode_auipc:
        begin
          cls[s] = frontend_pkg::class_upper;
          rs1[s] = 5'd0;
          imm[s] = {{32{word[s].u_format.imm[19]}}, word[s].u_format.imm, 12'd0};
        end
        frontend_pkg::opcode_jal:
        begin
          cls[s] = frontend_pkg::class_jal;
          rs1[s] = 5'd0;
          imm[s] = {{43{word[s].j_format.imm20}}, word[s].j_format.imm20,
                    word[s].j_format.imm19_12, word[s].j_format.imm11,
                    word[s].j_format.imm10_1, 1'b0};
        end
        default:
          cls[s] = frontend_pkg::class_other;           // fields passed raw
      endcase
    end
  end

  ////////////////////////////////////////
  // pipeline register
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset || flush)
      dec_valid <= '0;                                // redirect drops the pair
    else
      dec_valid <= accept ? fetch_valid : '0;
  end

  // payload registers load with each accepted pair
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      dec_pc    <= fetch_pc;
      dec_inst  <= fetch_inst;
      dec_class <= cls;
      dec_rd    <= rd;
      dec_rs1   <= rs1;
      dec_rs2   <= rs2;
      dec_imm   <= imm;
    end
  end

  a_no_valid_after_flush: assert property (
    @(posedge clock) disable iff (reset)
    $past(flush) |-> (dec_valid == '0)
  );

endmodule

// ==== src/fetch_queue.sv ====
////////////////////////////////////////
// fetch queue: circular buffer taking up to
// two predecoded entries per cycle and
// presenting the head one at a time
////////////////////////////////////////

`timescale 1ns/1ps

module fetch_queue (
  input  logic                                                      clock,
  input  logic                                                      reset,
  input  logic                                                      flush,
  input  logic [frontend_pkg::num_slots-1:0]                        dec_valid,
  input  logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] dec_pc,
  input  logic [frontend_pkg::num_slots-1:0][frontend_pkg::ilen-1:0] dec_inst,
  input  logic [frontend_pkg::num_slots-1:0][2:0]                   dec_class,
  input  logic [frontend_pkg::num_slots-1:0][4:0]                   dec_rd,
  input  logic [frontend_pkg::num_slots-1:0][4:0]                   dec_rs1,
  input  logic [frontend_pkg::num_slots-1:0][4:0]                   dec_rs2,
  input  logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] dec_imm,
  input  logic                                                      deq,
  output logic                                                      queue_room,
  output logic                                                      out_valid,
  output logic [frontend_pkg::xlen-1:0]                             inst_pc,
  output logic [frontend_pkg::ilen-1:0]                             inst,
  output logic [2:0]                                                inst_class,
  output logic [4:0]                                                inst_rd,
  output logic [4:0]                                                inst_rs1,
  output logic [4:0]                                                inst_rs2,
  output logic [frontend_pkg::xlen-1:0]                             inst_imm
);

  // entry storage, one array per field
  logic [frontend_pkg::xlen-1:0] pc_mem    [frontend_pkg::queue_depth];
  logic [frontend_pkg::ilen-1:0] inst_mem  [frontend_pkg::queue_depth];
  logic [2:0]                    class_mem [frontend_pkg::queue_depth];
  logic [4:0]                    rd_mem    [frontend_pkg::queue_depth];
  logic [4:0]                    rs1_mem   [frontend_pkg::queue_depth];
  logic [4:0]                    rs2_mem   [frontend_pkg::queue_depth];
  logic [frontend_pkg::xlen-1:0] imm_mem   [frontend_pkg::queue_depth];

  logic [frontend_pkg::queue_ptr_bits-1:0]   head;
  logic [frontend_pkg::queue_ptr_bits-1:0]   tail;
  logic [frontend_pkg::queue_count_bits-1:0] count;
  logic [frontend_pkg::queue_count_bits-1:0] num_wr;  // 0, 1 or 2
  logic [frontend_pkg::queue_ptr_bits-1:0]   wr_ptr [frontend_pkg::num_slots];
  logic                                      do_deq;

  assign num_wr = frontend_pkg::queue_count_bits'(dec_valid[0])
                + frontend_pkg::queue_count_bits'(dec_valid[1]);
  assign do_deq = deq && out_valid;             // deq on empty is ignored

  // slot 1 lands behind slot 0 when both are valid
  assign wr_ptr[0] = tail;
  assign wr_ptr[1] = tail + frontend_pkg::queue_ptr_bits'(dec_valid[0]);

  // room for the pair in predecode plus the pair being accepted
  assign queue_room = (frontend_pkg::queue_depth - count) >= 2 * frontend_pkg::num_slots;
  assign out_valid  = (count != '0);

  // head fields straight from storage
  assign inst_pc    = pc_mem[head];
  assign inst       = inst_mem[head];
  assign inst_class = class_mem[head];
  assign inst_rd    = rd_mem[head];
  assign inst_rs1   = rs1_mem[head];
  assign inst_rs2   = rs2_mem[head];
  assign inst_imm   = imm_mem[head];

  ////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset || flush)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      head  <= head + frontend_pkg::queue_ptr_bits'(do_deq);
      tail  <= tail + frontend_pkg::queue_ptr_bits'(num_wr);  // wraps at depth
      count <= count + num_wr - frontend_pkg::queue_count_bits'(do_deq);
    end
  end

  // entry storage write at the slot pointers
  always_ff @(posedge clock)
  begin
    for (int s = 0; s < frontend_pkg::num_slots; s++)
    begin
      if (dec_valid[s])
      begin
        pc_mem[wr_ptr[s]]    <= dec_pc[s];
        inst_mem[wr_ptr[s]]  <= dec_inst[s];
        class_mem[wr_ptr[s]] <= dec_class[s];
        rd_mem[wr_ptr[s]]    <= dec_rd[s];
        rs1_mem[wr_ptr[s]]   <= dec_rs1[s];
        rs2_mem[wr_ptr[s]]   <= dec_rs2[s];
        imm_mem[wr_ptr[s]]   <= dec_imm[s];
      end
    end
  end

  a_count_bound: assert property (
    @(posedge clock) disable iff (reset)
    count <= frontend_pkg::queue_depth
  );

  // the room level upstream must keep every write within capacity
  a_no_overflow: assert property (
    @(posedge clock) disable iff (reset)
    (|dec_valid) |-> (count + num_wr <= frontend_pkg::queue_depth)
  );

endmodule

// ==== src/frontend_top.sv ====
////////////////////////////////////////
// front end top: fetch, predecode and the
// fetch queue, redirect flushes all stages
////////////////////////////////////////

`timescale 1ns/1ps

module frontend_top (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          take_branch,
  input  logic [frontend_pkg::xlen-1:0] branch_target,
  input  logic [63:0]                   imem_data,
  input  logic                          imem_valid,
  input  logic                          deq,
  output logic [frontend_pkg::xlen-1:0] imem_addr,
  output logic                          out_valid,
  output logic [frontend_pkg::xlen-1:0] inst_pc,
  output logic [frontend_pkg::ilen-1:0] inst,
  output logic [2:0]                    inst_class,
  output logic [4:0]                    inst_rd,
  output logic [4:0]                    inst_rs1,
  output logic [4:0]                    inst_rs2,
  output logic [frontend_pkg::xlen-1:0] inst_imm
);

  // fetch to predecode
  logic [frontend_pkg::num_slots-1:0]                         fetch_valid;
  logic [frontend_pkg::num_slots-1:0][frontend_pkg::ilen-1:0] fetch_inst;
  logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] fetch_pc;

  // predecode to queue
  logic [frontend_pkg::num_slots-1:0]                         dec_valid;
  logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] dec_pc;
  logic [frontend_pkg::num_slots-1:0][frontend_pkg::ilen-1:0] dec_inst;
  logic [frontend_pkg::num_slots-1:0][2:0]                    dec_class;
  logic [frontend_pkg::num_slots-1:0][4:0]                    dec_rd;
  logic [frontend_pkg::num_slots-1:0][4:0]                    dec_rs1;
  logic [frontend_pkg::num_slots-1:0][4:0]                    dec_rs2;
  logic [frontend_pkg::num_slots-1:0][frontend_pkg::xlen-1:0] dec_imm;

  logic queue_room;                             // back-pressure to fetch

  fetch_stage u_fetch (
    .clock, .reset, .take_branch, .branch_target,
    .imem_data, .imem_valid, .queue_room,
    .imem_addr, .fetch_valid, .fetch_inst, .fetch_pc
  );

  predecode u_predecode (
    .clock, .reset,
    .flush (take_branch),
    .fetch_valid, .fetch_inst, .fetch_pc, .imem_valid, .queue_room,
    .dec_valid, .dec_pc, .dec_inst, .dec_class,
    .dec_rd, .dec_rs1, .dec_rs2, .dec_imm
  );

  fetch_queue u_queue (
    .clock, .reset,
    .flush (take_branch),                       // empties at the redirect edge
    .dec_valid, .dec_pc, .dec_inst, .dec_class,
    .dec_rd, .dec_rs1, .dec_rs2, .dec_imm, .deq,
    .queue_room, .out_valid, .inst_pc, .inst, .inst_class,
    .inst_rd, .inst_rs1, .inst_rs2, .inst_imm
  );

endmodule

// ==== verification/frontend_tb.sv ====
////////////////////////////////////////
// testbench for the two-wide front end:
// random instruction memory, random stalls,
// deq gaps and redirects, with every head
// checked against a reference decode
////////////////////////////////////////

`timescale 1ns/1ps

module frontend_tb;

  localparam int mem_words    = 1024;  // 4 KB, pc bits 11:2 index it
  localparam int total_insts  = 3000;
  localparam int idle_limit   = 200;   // cycles without a delivery
  localparam int cycle_limit  = 60000;
  localparam int quiet_cycles = 20;    // imem_valid held low after reset

  logic                          clock;
  logic                          reset;
  logic                          take_branch;
  logic [frontend_pkg::xlen-1:0] branch_target;
  logic [63:0]                   imem_data;
  logic                          imem_valid;
  logic                          deq;
  logic [frontend_pkg::xlen-1:0] imem_addr;
  logic                          out_valid;
  logic [frontend_pkg::xlen-1:0] inst_pc;
  logic [frontend_pkg::ilen-1:0] inst;
  logic [2:0]                    inst_class;
  logic [4:0]                    inst_rd;
  logic [4:0]                    inst_rs1;
  logic [4:0]                    inst_rs2;
  logic [frontend_pkg::xlen-1:0] inst_imm;

  logic [frontend_pkg::ilen-1:0] mem [mem_words];   // instruction memory model
  logic [frontend_pkg::xlen-1:0] expected_pc;      // next pc the model wants
  int                            delivered;
  int                            cycles;
  int                            idle;
  int                            gap;              // cycles left in a deq gap

  frontend_top UUT (
    .clock, .reset, .take_branch, .branch_target, .imem_data, .imem_valid, .deq,
    .imem_addr, .out_valid, .inst_pc, .inst, .inst_class,
    .inst_rd, .inst_rs1, .inst_rs2, .inst_imm
  );

  // memory answers the current address at once, slot 0 in the low half
  assign imem_data = {mem[{imem_addr[11:3], 1'b1}], mem[{imem_addr[11:3], 1'b0}]};

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;                   // 10 ns period
  end

  ////////////////////////////////////////
  // failure reporting and compares
  ////////////////////////////////////////
  task automatic report_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_word(input string name, input logic [frontend_pkg::ilen-1:0] got,
                            input logic [frontend_pkg::ilen-1:0] exp);
    if (got !== exp)
    begin
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_addr(input string name, input logic [frontend_pkg::xlen-1:0] got,
                            input logic [frontend_pkg::xlen-1:0] exp);
    if (got !== exp)
    begin
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp)
    begin
      $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_class(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
    begin
      $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic logic [6:0] pick_opcode(input int n);
    case (n)
      0:       return frontend_pkg::opcode_op;
      1:       return frontend_pkg::opcode_op_imm;
      2:       return frontend_pkg::opcode_load;
      3:       return frontend_pkg::opcode_store;
      4:       return frontend_pkg::opcode_branch;
      5:       return frontend_pkg::opcode_jal;
      6:       return frontend_pkg::opcode_jalr;
      7:       return frontend_pkg::opcode_lui;
      8:       return frontend_pkg::opcode_auipc;
      default: return 7'b1110011;                 // system opcode, unknown to predecode
    endcase
  endfunction

  // fields a format lacks are expected as zero
  task automatic predict_decode(input logic [frontend_pkg::ilen-1:0] word,
                                output logic [2:0] cls, output logic [4:0] rd,
                                output logic [4:0] rs1, output logic [4:0] rs2,
                                output logic [frontend_pkg::xlen-1:0] imm);
    frontend_pkg::inst_word_u w;
    w   = word;
    cls = frontend_pkg::class_other;
    rd  = '0;
    rs1 = '0;
    rs2 = '0;
    imm = '0;
    case (w.raw[6:0])
      frontend_pkg::opcode_op:
      begin
        cls = frontend_pkg::class_alu;
        rd  = w.r_format.rd;
        rs1 = w.r_format.rs1;
        rs2 = w.r_format.rs2;
      end
      frontend_pkg::opcode_op_imm, frontend_pkg::opcode_load, frontend_pkg::opcode_jalr:
      begin
        case (w.raw[6:0])
          frontend_pkg::opcode_load: cls = frontend_pkg::class_load;
          frontend_pkg::opcode_jalr: cls = frontend_pkg::class_jalr;
          default:                   cls = frontend_pkg::class_alu;
        endcase
        rd  = w.i_format.rd;
        rs1 = w.i_format.rs1;
        imm = $signed(w.i_format.imm);             // sign carried by the cast
      end
      frontend_pkg::opcode_store:
      begin
        cls = frontend_pkg::class_store;
        rs1 = w.s_format.rs1;
        rs2 = w.s_format.rs2;
        imm = $signed({w.s_format.imm_hi, w.s_format.imm_lo});
      end
      frontend_pkg::opcode_branch:
      begin
        cls = frontend_pkg::class_branch;
        rs1 = w.b_format.rs1;
        rs2 = w.b_format.rs2;
        imm = $signed({w.b_format.imm12, w.b_format.imm11, w.b_format.imm10_5,
                       w.b_format.imm4_1, 1'b0});
      end
      frontend_pkg::opcode_jal:
      begin
        cls = frontend_pkg::class_jal;
        rd  = w.j_format.rd;
        imm = $signed({w.j_format.imm20, w.j_format.imm19_12, w.j_format.imm11,
                       w.j_format.imm10_1, 1'b0});
      end
      frontend_pkg::opcode_lui, frontend_pkg::opcode_auipc:
      begin
        cls = frontend_pkg::class_upper;
        rd  = w.u_format.rd;
        imm = $signed({w.u_format.imm, 12'd0});    // 32-bit value, then extended
      end
      default:
      begin
        rd  = w.r_format.rd;                       // unknown opcode, raw fields
        rs1 = w.r_format.rs1;
      end
    endcase
  endtask

  // compare the queue head with the model, then step the expected pc
  task automatic check_head();
    logic [frontend_pkg::ilen-1:0] word;
    logic [2:0]                    cls;
    logic [4:0]                    rd;
    logic [4:0]                    rs1;
    logic [4:0]                    rs2;
    logic [frontend_pkg::xlen-1:0] imm;
    word = mem[expected_pc[11:2]];
    predict_decode(word, cls, rd, rs1, rs2, imm);
    check_addr("inst_pc", inst_pc, expected_pc);
    check_word("inst", inst, word);
    check_class("inst_class", inst_class, cls);
    check_reg("inst_rd", inst_rd, rd);
    check_reg("inst_rs1", inst_rs1, rs1);
    check_reg("inst_rs2", inst_rs2, rs2);
    check_addr("inst_imm", inst_imm, imm);
    expected_pc = expected_pc + 64'd4;
  endtask

  ////////////////////////////////////////
  // stimulus and checking
  ////////////////////////////////////////
  initial
  begin
    void'($urandom(32'hd98a));                     // one seed for the whole run
    for (int a = 0; a < mem_words; a++)
    begin
      mem[a]      = $urandom;
      mem[a][6:0] = pick_opcode($urandom % 10);    // nine known opcodes and one unknown
    end
    reset         = 1'b1;
    take_branch   = 1'b0;
    branch_target = '0;
    imem_valid    = 1'b0;
    deq           = 1'b0;
    expected_pc   = '0;                            // boot pc
    delivered     = 0;
    cycles        = 0;
    idle          = 0;
    gap           = 0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    // nothing comes out before memory answers
    for (int c = 0; c < quiet_cycles; c++)
    begin
      @(negedge clock);
      check_flag("out_valid", out_valid, 1'b0);
      check_addr("imem_addr", imem_addr, '0);
    end

    while (delivered < total_insts && cycles < cycle_limit)
    begin
      @(posedge clock);
      imem_valid <= ($urandom % 4) != 0;           // stalls about one cycle in four
      if (($urandom % 80) == 0)
      begin
        take_branch   <= 1'b1;
        branch_target <= 64'(($urandom % (mem_words / 2)) * 8);
        deq           <= 1'b0;                     // never deq with a redirect
      end
      else
      begin
        take_branch <= 1'b0;
        if (gap > 0)
        begin
          deq <= 1'b0;
          gap = gap - 1;
        end
        else if (($urandom % 50) == 0)
        begin
          deq <= 1'b0;
          gap = 20 + ($urandom % 40);              // long consumer stall
        end
        else
          deq <= $urandom % 2;
      end

      @(negedge clock);                            // inputs and head are settled here
      if (take_branch)
        expected_pc = branch_target;               // older instructions are gone
      else if (deq && out_valid)
      begin
        check_head();
        delivered = delivered + 1;
        idle      = 0;
      end
      else
        idle = idle + 1;
      if (idle > idle_limit)
      begin
        $display("timeout: the front end stopped delivering instructions for %0d cycles",
                 idle_limit);
        report_failure();
      end
      cycles = cycles + 1;
    end

    if (delivered == total_insts)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("run limit of %0d cycles reached after %0d instructions",
               cycle_limit, delivered);
      report_failure();
    end
  end

endmodule

// ==== flist.f ====
src/frontend_pkg.sv
src/fetch_stage.sv
src/predecode.sv
src/fetch_queue.sv
src/frontend_top.sv
verification/frontend_tb.sv
